/* adc_capture_pkg.sv */
package adc_capture_pkg;

	// frame geometry
	localparam int NUM_CH    = 8;
	localparam int SAMPLE_W  = 12;
	localparam int LANE_W    = 16;   // sample zero-extended into a lane
	localparam int FRAME_W   = NUM_CH * SAMPLE_W;
	localparam int WORD_W    = 128;
	localparam int BYTE_EN_W = WORD_W / 8;

	// ram port and control widths
	localparam int ADDR_W = 15;
	localparam int LEN_W  = 16;
	localparam int DIV_W  = 4;
	localparam int IRQ_W  = 32;

	// interrupt codes seen by the host
	localparam logic [IRQ_W-1:0] IRQ_CLEAR = 32'h00000000;
	localparam logic [IRQ_W-1:0] IRQ_BUSY  = 32'h0000000f;
	localparam logic [IRQ_W-1:0] IRQ_DONE  = 32'h000000ff;

	typedef enum logic [1:0]
	{
		CAP_IDLE = 2'd0,
		CAP_RUN  = 2'd1,
		CAP_DONE = 2'd2
	} capture_state_t;

	typedef enum logic
	{
		DECIM_PICK = 1'b0,   // keep first frame of each group
		DECIM_SUM  = 1'b1    // lane-wise sum over the group
	} decim_mode_t;

endpackage

/* capture_ctrl.sv */
module capture_ctrl import adc_capture_pkg::*;
(
	input  logic             adc_clkinp,
	input  logic             rst,
	input  logic             trig,
	input  logic             state_reset,
	input  logic             record_done,
	output logic             run,
	output logic             trig_ack,
	output logic             chip_sel,
	output logic [IRQ_W-1:0] rcv_irq
);

	capture_state_t state;

	// state_reset wins over everything except rst
	always_ff @(posedge adc_clkinp)
	begin
		if (rst)
		begin
			state   <= CAP_IDLE;
			rcv_irq <= IRQ_CLEAR;
		end
		else if (state_reset)
		begin
			state   <= CAP_IDLE;
			rcv_irq <= IRQ_CLEAR;
		end
		else
		begin
			case (state)
				CAP_IDLE:
				begin
					if (trig)
					begin
						state <= CAP_RUN;
						if (rcv_irq == IRQ_CLEAR)
						begin
							rcv_irq <= IRQ_BUSY;
						end
					end
				end
				CAP_RUN:
				begin
					if (record_done)   // last word went out this cycle
					begin
						state   <= CAP_DONE;
						rcv_irq <= IRQ_DONE;
					end
				end
				CAP_DONE:
				begin
					state <= CAP_DONE;   // parked until state_reset
				end
				default:
				begin
					state <= CAP_IDLE;
				end
			endcase
		end
	end

	// all three follow the run state directly
	assign run      = (state == CAP_RUN);
	assign trig_ack = (state == CAP_RUN);
	assign chip_sel = (state == CAP_RUN);

endmodule

/* sample_decimator.sv */
module sample_decimator import adc_capture_pkg::*;
(
	input  logic               adc_clkinp,
	input  logic               rst,
	input  logic               run,
	input  logic [FRAME_W-1:0] adc_samples,
	input  logic [DIV_W-1:0]   down_sample_div,
	input  decim_mode_t        sampling_mode,
	output logic               frame_valid,
	output logic [WORD_W-1:0]  frame_data
);

	logic [DIV_W-1:0]  grp_cnt;   // position inside current group
	logic [WORD_W-1:0] acc;       // held first frame or running sum
	logic [WORD_W-1:0] widened;
	logic [WORD_W-1:0] sum_next;
	logic [WORD_W-1:0] pick_next;
	logic [WORD_W-1:0] acc_next;
	logic              grp_first;
	logic              grp_last;

	assign grp_first = (grp_cnt == '0);
	assign grp_last  = (grp_cnt >= down_sample_div);   // also recovers if D shrinks mid-group

	// per-lane widen and add, wraps at 16 bits
	for (genvar k = 0; k < NUM_CH; k++)
	begin : g_lane
		assign widened[k*LANE_W +: LANE_W] =
			{{(LANE_W-SAMPLE_W){1'b0}}, adc_samples[k*SAMPLE_W +: SAMPLE_W]};

		assign sum_next[k*LANE_W +: LANE_W] =
			(grp_first ? {LANE_W{1'b0}} : acc[k*LANE_W +: LANE_W])
			+ widened[k*LANE_W +: LANE_W];
	end

	assign pick_next = grp_first ? widened : acc;
	assign acc_next  = (sampling_mode == DECIM_SUM) ? sum_next : pick_next;

	always_ff @(posedge adc_clkinp)
	begin
		if (rst || !run)
		begin
			grp_cnt     <= '0;
			frame_valid <= 1'b0;
		end
		else
		begin
			frame_valid <= grp_last;
			if (grp_last)
			begin
				grp_cnt <= '0;
			end
			else
			begin
				grp_cnt <= grp_cnt + 1'b1;
			end
		end
	end

	// payload path
	always_ff @(posedge adc_clkinp)
	begin
		if (!run)
		begin
			acc <= '0;
		end
		else
		begin
			acc <= acc_next;
			if (grp_last)
			begin
				frame_data <= acc_next;
			end
		end
	end

endmodule

/* sample_packer.sv */
module sample_packer import adc_capture_pkg::*;
(
	input  logic              adc_clkinp,
	input  logic              rst,
	input  logic              run,
	input  logic              compress,
	input  logic              frame_valid,
	input  logic [WORD_W-1:0] frame_data,
	output logic              word_valid,
	output logic [WORD_W-1:0] word_data
);

	logic [1:0]         phase;   // frames seen mod 4
	logic [FRAME_W-1:0] carry;   // leftover stream bits, low aligned
	logic [FRAME_W-1:0] fld;     // 12-bit fields of this frame
	logic [WORD_W-1:0]  pack_word;
	logic [FRAME_W-1:0] carry_next;

	// drop the top nibble of each lane, lane 0 lowest
	for (genvar k = 0; k < NUM_CH; k++)
	begin : g_field
		assign fld[k*SAMPLE_W +: SAMPLE_W] = frame_data[k*LANE_W +: SAMPLE_W];
	end

	// carry holds 96, 64 or 32 valid bits going into phase 1, 2, 3
	always_comb
	begin
		pack_word  = '0;
		carry_next = '0;
		case (phase)
			2'd0:
			begin
				carry_next = fld;   // not enough for a word yet
			end
			2'd1:
			begin
				pack_word  = {fld[31:0], carry[95:0]};
				carry_next = {32'b0, fld[95:32]};
			end
			2'd2:
			begin
				pack_word  = {fld[63:0], carry[63:0]};
				carry_next = {64'b0, fld[95:64]};
			end
			default:
			begin
				pack_word  = {fld[95:0], carry[31:0]};
				carry_next = '0;   // stream realigned
			end
		endcase
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (rst || !run)
		begin
			phase      <= 2'd0;
			word_valid <= 1'b0;
		end
		else if (frame_valid)
		begin
			if (compress)
			begin
				phase      <= phase + 1'b1;
				word_valid <= (phase != 2'd0);
			end
			else
			begin
				word_valid <= 1'b1;
			end
		end
		else
		begin
			word_valid <= 1'b0;
		end
	end

	// partial bits die with run
	always_ff @(posedge adc_clkinp)
	begin
		if (!run)
		begin
			carry <= '0;
		end
		else if (frame_valid)
		begin
			if (compress)
			begin
				carry     <= carry_next;
				word_data <= pack_word;
			end
			else
			begin
				word_data <= frame_data;   // raw lanes as is
			end
		end
	end

endmodule

/* ram_writer.sv */
module ram_writer import adc_capture_pkg::*;
(
	input  logic                 adc_clkinp,
	input  logic                 rst,
	input  logic                 run,
	input  logic [LEN_W-1:0]     rec_length,
	input  logic                 word_valid,
	input  logic [WORD_W-1:0]    word_data,
	output logic                 wr_en,
	output logic [BYTE_EN_W-1:0] byte_en,
	output logic [WORD_W-1:0]    wr_data,
	output logic [ADDR_W-1:0]    wr_addr,
	output logic                 record_done
);

	logic [LEN_W-1:0] wr_cnt;   // words written this capture
	logic [LEN_W-1:0] wr_cnt_nxt;
	logic             finished;
	logic             len_bad;   // zero or more than the address space holds

	assign wr_cnt_nxt = wr_cnt + 1'b1;
	assign len_bad    = (rec_length == '0) || (rec_length > LEN_W'(2 ** ADDR_W));

	always_ff @(posedge adc_clkinp)
	begin
		if (rst || !run)
		begin
			wr_cnt      <= '0;
			finished    <= 1'b0;
			wr_en       <= 1'b0;
			byte_en     <= '0;
			record_done <= 1'b0;
		end
		else
		begin
			wr_en       <= 1'b0;
			byte_en     <= '0;
			record_done <= 1'b0;
			if (word_valid && !finished)
			begin
				if (len_bad)
				begin
					record_done <= 1'b1;   // end at once, nothing written
					finished    <= 1'b1;
				end
				else
				begin
					wr_en   <= 1'b1;
					byte_en <= '1;
					wr_cnt  <= wr_cnt_nxt;
					if (wr_cnt_nxt >= rec_length)
					begin
						record_done <= 1'b1;
						finished    <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (word_valid)
		begin
			wr_data <= word_data;
			wr_addr <= wr_cnt[ADDR_W-1:0];
		end
	end

endmodule

/* adc_capture_top.sv */
module adc_capture_top import adc_capture_pkg::*;
(
	input  logic                 adc_clkinp,
	input  logic                 rst,
	input  logic                 trig,
	input  logic                 state_reset,
	input  logic [LEN_W-1:0]     rec_length,
	input  logic [DIV_W-1:0]     down_sample_div,
	input  decim_mode_t          sampling_mode,
	input  logic                 compress,
	input  logic [FRAME_W-1:0]   adc_samples,
	output logic                 trig_ack,
	output logic [IRQ_W-1:0]     rcv_irq,
	output logic                 chip_sel,
	output logic                 wr_en,
	output logic [BYTE_EN_W-1:0] byte_en,
	output logic [WORD_W-1:0]    wr_data,
	output logic [ADDR_W-1:0]    wr_addr
);

	logic              run;
	logic              frame_valid;
	logic [WORD_W-1:0] frame_data;
	logic              word_valid;
	logic [WORD_W-1:0] word_data;
	logic              record_done;

	capture_ctrl i_ctrl
	(
		.adc_clkinp  (adc_clkinp),
		.rst         (rst),
		.trig        (trig),
		.state_reset (state_reset),
		.record_done (record_done),
		.run         (run),
		.trig_ack    (trig_ack),
		.chip_sel    (chip_sel),
		.rcv_irq     (rcv_irq)
	);

	// pick or sum over groups of D+1 frames
	sample_decimator i_decim
	(
		.adc_clkinp      (adc_clkinp),
		.rst             (rst),
		.run             (run),
		.adc_samples     (adc_samples),
		.down_sample_div (down_sample_div),
		.sampling_mode   (sampling_mode),
		.frame_valid     (frame_valid),
		.frame_data      (frame_data)
	);

	sample_packer i_packer
	(
		.adc_clkinp  (adc_clkinp),
		.rst         (rst),
		.run         (run),
		.compress    (compress),
		.frame_valid (frame_valid),
		.frame_data  (frame_data),
		.word_valid  (word_valid),
		.word_data   (word_data)
	);

	// record_done closes the loop back to the FSM
	ram_writer i_writer
	(
		.adc_clkinp  (adc_clkinp),
		.rst         (rst),
		.run         (run),
		.rec_length  (rec_length),
		.word_valid  (word_valid),
		.word_data   (word_data),
		.wr_en       (wr_en),
		.byte_en     (byte_en),
		.wr_data     (wr_data),
		.wr_addr     (wr_addr),
		.record_done (record_done)
	);

endmodule

/* tb_clock.sv */
module tb_clock
(
	output logic adc_clkinp,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		adc_clkinp = 1'b0;
		forever #5 adc_clkinp = ~adc_clkinp;   // 10 ns period
	end

	initial
	begin
		rst = 1'b1;
		repeat (4) @(posedge adc_clkinp);
		rst <= 1'b0;
	end

endmodule

/* tb_adc_capture.sv */
module tb_adc_capture import adc_capture_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 300;   // cycles per wait loop

	logic                 adc_clkinp;
	logic                 rst;
	logic                 trig;
	logic                 state_reset;
	logic [LEN_W-1:0]     rec_length;
	logic [DIV_W-1:0]     down_sample_div;
	decim_mode_t          sampling_mode;
	logic                 compress;
	logic [FRAME_W-1:0]   adc_samples = '0;
	logic                 trig_ack;
	logic [IRQ_W-1:0]     rcv_irq;
	logic                 chip_sel;
	logic                 wr_en;
	logic [BYTE_EN_W-1:0] byte_en;
	logic [WORD_W-1:0]    wr_data;
	logic [ADDR_W-1:0]    wr_addr;

	// reference model state
	logic [15:0]         lfsr_state = 16'd67;
	logic [WORD_W-1:0]   exp_q[$];
	int                  grp_pos;
	logic [LANE_W-1:0]   lane_sum[NUM_CH];
	logic [WORD_W-1:0]   first_frame;
	logic [2*WORD_W-1:0] stream;       // 12-bit field stream, oldest bits low
	int                  stream_len;
	capture_state_t      exp_state;
	int                  wr_count;
	logic                exp_avail;
	logic [WORD_W-1:0]   exp_head;

	tb_clock i_clock
	(
		.adc_clkinp (adc_clkinp),
		.rst        (rst)
	);

	adc_capture_top i_dut
	(
		.adc_clkinp      (adc_clkinp),
		.rst             (rst),
		.trig            (trig),
		.state_reset     (state_reset),
		.rec_length      (rec_length),
		.down_sample_div (down_sample_div),
		.sampling_mode   (sampling_mode),
		.compress        (compress),
		.adc_samples     (adc_samples),
		.trig_ack        (trig_ack),
		.rcv_irq         (rcv_irq),
		.chip_sel        (chip_sel),
		.wr_en           (wr_en),
		.byte_en         (byte_en),
		.wr_data         (wr_data),
		.wr_addr         (wr_addr)
	);

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("sim failed");
		$fatal(1, "run stopped at first error");
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	// one LFSR step per sample bit
	function automatic logic [FRAME_W-1:0] random_frame();
		logic [FRAME_W-1:0] f;
		for (int i = 0; i < FRAME_W; i++)
		begin
			f[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
		return f;
	endfunction

	function automatic logic [IRQ_W-1:0] irq_for(input capture_state_t s);
		case (s)
			CAP_RUN:  return IRQ_BUSY;
			CAP_DONE: return IRQ_DONE;
			default:  return IRQ_CLEAR;
		endcase
	endfunction

	function automatic logic [WORD_W-1:0] widen(input logic [FRAME_W-1:0] f);
		logic [WORD_W-1:0] w;
		w = '0;
		for (int k = 0; k < NUM_CH; k++)
		begin
			w[k*LANE_W +: SAMPLE_W] = f[k*SAMPLE_W +: SAMPLE_W];
		end
		return w;
	endfunction

	task automatic clear_model();
		grp_pos    = 0;
		stream     = '0;
		stream_len = 0;
		exp_q.delete();
	endtask

	// raw word, or append 96 field bits and cut whole words off the bottom
	task automatic pack_frame(input logic [WORD_W-1:0] lanes);
		logic [FRAME_W-1:0] fields;
		if (!compress)
		begin
			exp_q.push_back(lanes);
			return;
		end
		for (int k = 0; k < NUM_CH; k++)
		begin
			fields[k*SAMPLE_W +: SAMPLE_W] = lanes[k*LANE_W +: SAMPLE_W];
		end
		stream = stream | ((2*WORD_W)'(fields) << stream_len);
		stream_len += FRAME_W;
		if (stream_len >= WORD_W)
		begin
			exp_q.push_back(stream[WORD_W-1:0]);
			stream = stream >> WORD_W;
			stream_len -= WORD_W;
		end
	endtask

	task automatic model_frame(input logic [FRAME_W-1:0] f);
		logic [WORD_W-1:0] out;
		out = '0;
		if (grp_pos == 0)
		begin
			first_frame = widen(f);
			for (int k = 0; k < NUM_CH; k++)
			begin
				lane_sum[k] = '0;
			end
		end
		for (int k = 0; k < NUM_CH; k++)
		begin
			lane_sum[k] = lane_sum[k] + LANE_W'(f[k*SAMPLE_W +: SAMPLE_W]);   // wraps at 2^16
		end
		if (grp_pos == int'(down_sample_div))
		begin
			grp_pos = 0;
			if (sampling_mode == DECIM_SUM)
			begin
				for (int k = 0; k < NUM_CH; k++)
				begin
					out[k*LANE_W +: LANE_W] = lane_sum[k];
				end
			end
			else
			begin
				out = first_frame;
			end
			pack_frame(out);
		end
		else
		begin
			grp_pos++;
		end
	endtask

	always @(posedge adc_clkinp)
	begin
		adc_samples <= random_frame();
	end

	// frames enter the model from the cycle trig_ack is high
	always @(posedge adc_clkinp)
	begin
		if (rst)
		begin
			clear_model();
			exp_state <= CAP_IDLE;
			wr_count  <= 0;
			exp_avail <= 1'b0;
			exp_head  <= '0;
		end
		else
		begin
			if (trig_ack)
			begin
				model_frame(adc_samples);
				if (wr_en && exp_q.size() > 0)
				begin
					void'(exp_q.pop_front());
				end
				wr_count <= wr_count + (wr_en ? 1 : 0);
			end
			else
			begin
				clear_model();
				wr_count <= 0;
			end
			exp_avail <= (exp_q.size() > 0);
			exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
			if (state_reset)
			begin
				exp_state <= CAP_IDLE;
			end
			else if (exp_state == CAP_IDLE && trig)
			begin
				exp_state <= CAP_RUN;
			end
			else if (exp_state == CAP_RUN && wr_en && wr_count + 1 == int'(rec_length))
			begin
				exp_state <= CAP_DONE;
			end
		end
	end

	a_trig_ack: assert property (@(posedge adc_clkinp) disable iff (rst)
		trig_ack == (exp_state == CAP_RUN))
		else stop_on_error($sformatf("FAIL t=%0t trig_ack exp=%0b got=%0b", $time,
			$sampled(exp_state == CAP_RUN), $sampled(trig_ack)));

	a_chip_sel: assert property (@(posedge adc_clkinp) disable iff (rst)
		chip_sel == (exp_state == CAP_RUN))
		else stop_on_error($sformatf("FAIL t=%0t chip_sel exp=%0b got=%0b", $time,
			$sampled(exp_state == CAP_RUN), $sampled(chip_sel)));

	a_rcv_irq: assert property (@(posedge adc_clkinp) disable iff (rst)
		rcv_irq == irq_for(exp_state))
		else stop_on_error($sformatf("FAIL t=%0t rcv_irq exp=%h got=%h", $time,
			irq_for($sampled(exp_state)), $sampled(rcv_irq)));

	a_wr_idle: assert property (@(posedge adc_clkinp) disable iff (rst)
		!trig_ack |-> !wr_en)
		else stop_on_error($sformatf("FAIL t=%0t wr_en exp=0 got=%0b", $time, $sampled(wr_en)));

	a_byte_en: assert property (@(posedge adc_clkinp) disable iff (rst)
		byte_en == {BYTE_EN_W{wr_en}})
		else stop_on_error($sformatf("FAIL t=%0t byte_en exp=%h got=%h", $time,
			{BYTE_EN_W{$sampled(wr_en)}}, $sampled(byte_en)));

	a_wr_pending: assert property (@(posedge adc_clkinp) disable iff (rst)
		wr_en |-> exp_avail)
		else stop_on_error("RAM write seen while the model had no word to expect");

	a_wr_data: assert property (@(posedge adc_clkinp) disable iff (rst)
		wr_en |-> (wr_data == exp_head))
		else stop_on_error($sformatf("FAIL t=%0t wr_data exp=%h got=%h", $time,
			$sampled(exp_head), $sampled(wr_data)));

	a_wr_addr: assert property (@(posedge adc_clkinp) disable iff (rst)
		wr_en |-> (wr_addr == ADDR_W'(wr_count)))
		else stop_on_error($sformatf("FAIL t=%0t wr_addr exp=%h got=%h", $time,
			ADDR_W'($sampled(wr_count)), $sampled(wr_addr)));

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (rst)
		begin
			@(posedge adc_clkinp);
			n++;
			if (n > WAIT_LIMIT)
			begin
				stop_on_error("reset was never released");
			end
		end
	endtask

	task automatic wait_trig_ack(input logic level, input string what);
		int n;
		n = 0;
		while (trig_ack !== level)
		begin
			@(posedge adc_clkinp);
			n++;
			if (n > WAIT_LIMIT)
			begin
				stop_on_error(what);
			end
		end
	endtask

	// trig stays high after done, DONE has to ignore it
	task automatic run_capture(input logic [DIV_W-1:0] d, input decim_mode_t mode,
		input logic comp, input logic [LEN_W-1:0] len);
		@(posedge adc_clkinp);
		down_sample_div <= d;
		sampling_mode   <= mode;
		compress        <= comp;
		rec_length      <= len;
		trig            <= 1'b1;
		wait_trig_ack(1'b1, "capture did not start after trig");
		wait_trig_ack(1'b0, "capture did not finish within the time limit");
		repeat (8) @(posedge adc_clkinp);
		state_reset <= 1'b1;
		trig        <= 1'b0;
		@(posedge adc_clkinp);
		state_reset <= 1'b0;
		repeat (4) @(posedge adc_clkinp);
	endtask

	initial
	begin
		trig            = 1'b0;
		state_reset     = 1'b0;
		rec_length      = '0;
		down_sample_div = '0;
		sampling_mode   = DECIM_PICK;
		compress        = 1'b0;
		wait_reset_release();
		repeat (6) @(posedge adc_clkinp);   // idle checks
		run_capture(4'd0, DECIM_PICK, 1'b0, 16'd6);
		run_capture(4'd3, DECIM_PICK, 1'b0, 16'd4);
		run_capture(4'd3, DECIM_SUM, 1'b0, 16'd4);
		run_capture(4'd0, DECIM_PICK, 1'b1, 16'd6);
		run_capture(4'd1, DECIM_SUM, 1'b1, 16'd3);
		repeat (4) @(posedge adc_clkinp);
		$display("sim passed");
		$finish;
	end

endmodule

/* list.f */
adc_capture_pkg.sv
capture_ctrl.sv
sample_decimator.sv
sample_packer.sv
ram_writer.sv
adc_capture_top.sv
tb_clock.sv
tb_adc_capture.sv

/* Makefile */
SRCS := $(shell cat list.f)
BIN  := obj_dir/Vtb_adc_capture

.PHONY: all run clean

all: run

$(BIN): list.f $(SRCS)
	verilator --binary --assert --timescale 1ns/100ps -f list.f \
		--top-module tb_adc_capture -o Vtb_adc_capture

run: $(BIN)
	@out=$$(./$(BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -q "sim passed"

clean:
	rm -rf obj_dir
